//--- verilog/distrib_macros.svh
/*
  Build-time sizing for the stream distributor.
  DISTRIB_FIFO_DEPTH must be a power of two and at least 2.
*/
`ifndef DISTRIB_MACROS_SVH
`define DISTRIB_MACROS_SVH

// number of output channels
`define DISTRIB_CHANNELS 4

// payload bits per beat, not counting last
`define DISTRIB_DATA_WIDTH 32

// entries in each per-channel FIFO
`define DISTRIB_FIFO_DEPTH 8

`endif

//--- verilog/distrib_pkg.sv
/*
  Types shared by the distributor core, the channel FIFOs and the top level.
  Sizes come from the `define header and are fixed at build time.
*/
`default_nettype none
`include "distrib_macros.svh"

package distrib_pkg;

  //////////////////////////////
  // stream payload

  // one beat of the input and output streams
  typedef struct packed {
    logic [`DISTRIB_DATA_WIDTH-1:0] data;
    logic                           last;
  } beat_t;

  // one bit per output channel
  typedef logic [`DISTRIB_CHANNELS-1:0] chan_mask_t;

  // per-channel beats between core and FIFOs
  typedef beat_t [`DISTRIB_CHANNELS-1:0] beat_vec_t;

  //////////////////////////////
  // configuration

  // request on the config port, room for more fields later
  typedef struct packed {
    chan_mask_t mask;
  } cfg_write_t;

endpackage

`default_nettype wire

//--- verilog/stream_fifo.sv
/*
  First-word fall-through FIFO for one channel. A write shows at the
  output one cycle later. Depth comes from DISTRIB_FIFO_DEPTH and must
  be a power of two so the pointers wrap on their own.
*/
`timescale 1ns/1ps
`default_nettype none
`include "distrib_macros.svh"

module stream_fifo (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               in_valid,
  output logic                    in_ready,
  input  wire distrib_pkg::beat_t in_beat,
  output logic                    out_valid,
  input  wire logic               out_ready,
  output distrib_pkg::beat_t      out_beat
);

  import distrib_pkg::*;

  localparam int depth = `DISTRIB_FIFO_DEPTH;
  localparam int aw    = $clog2(depth);
  localparam logic [aw:0] count_full = (aw + 1)'(depth);

  beat_t         mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;
  logic          wr_en;
  logic          rd_en;

  assign in_ready  = (count != count_full);
  assign out_valid = (count != '0);
  assign wr_en     = in_valid & in_ready;
  assign rd_en     = out_valid & out_ready;

  //////////////////////////////
  // pointers and occupancy

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // head entry read straight from the array
  assign out_beat = mem[rd_ptr];

  //////////////////////////////
  // checks

  a_count_range : assert property (
    @(posedge clk) disable iff (rst)
    count <= count_full
  );

  // stalled head must not move or change
  a_head_stable : assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  );

endmodule

`default_nettype wire

//--- verilog/stream_distrib.sv
/*
  Copies each input beat to every enabled channel. in_ready is registered,
  so with no back-pressure a beat is accepted every second cycle.
  The mask is sampled on the input transfer and a later mask change
  does not affect a beat already handed to the channels.
*/
`timescale 1ns/1ps
`default_nettype none
`include "distrib_macros.svh"

module stream_distrib (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    in_valid,
  output logic                         in_ready,
  input  wire distrib_pkg::beat_t      in_beat,
  input  wire distrib_pkg::chan_mask_t enable_mask,
  output distrib_pkg::chan_mask_t      dist_valid,
  input  wire distrib_pkg::chan_mask_t dist_ready,
  output distrib_pkg::beat_vec_t       dist_beat,
  output logic                         beat_taken,
  output logic                         beat_last
);

  import distrib_pkg::*;

  // channels that already have the current beat
  chan_mask_t done;
  chan_mask_t done_next;
  chan_mask_t dist_xfer;
  logic       in_xfer;

  assign in_xfer   = in_valid & in_ready;
  assign dist_xfer = dist_valid & dist_ready;
  assign done_next = done | dist_xfer;

  // packet boundary info for the config block
  assign beat_taken = in_xfer;
  assign beat_last  = in_beat.last;

  //////////////////////////////
  // input side

  // done starts full so in_ready comes up one cycle after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      done     <= '1;
      in_ready <= 1'b0;
    end else if (in_xfer) begin
      // disabled channels count as done right away
      done     <= ~enable_mask;
      in_ready <= 1'b0;
    end else begin
      done     <= done_next;
      in_ready <= &done_next;
    end
  end

  //////////////////////////////
  // channel side

  // valid held until the channel takes it
  always_ff @(posedge clk) begin
    if (rst) begin
      dist_valid <= '0;
    end else if (in_xfer) begin
      dist_valid <= enable_mask;
    end else begin
      dist_valid <= dist_valid & ~dist_xfer;
    end
  end

  always_ff @(posedge clk) begin
    for (int n = 0; n < `DISTRIB_CHANNELS; n++) begin
      if (in_xfer && enable_mask[n]) begin
        dist_beat[n] <= in_beat;
      end
    end
  end

  //////////////////////////////
  // checks

  for (genvar n = 0; n < `DISTRIB_CHANNELS; n++) begin : g_chk
    // a held beat only leaves through a handshake
    a_valid_hold : assert property (
      @(posedge clk) disable iff (rst)
      $fell(dist_valid[n]) |-> $past(dist_ready[n])
    );

    // masked and finished channels hold no valid
    a_masked_idle : assert property (
      @(posedge clk) disable iff (rst)
      dist_valid[n] |-> !done[n]
    );
  end

  // next beat never accepted while a channel still holds the last one
  a_no_overrun : assert property (
    @(posedge clk) disable iff (rst)
    in_xfer |-> (dist_valid & ~dist_ready) == '0
  );

endmodule

`default_nettype wire

//--- verilog/distrib_config.sv
/*
  Holds the channel enable mask. A write is accepted only between packets,
  so cfg_ready may stay low for a whole packet. Mask is all ones after reset.
*/
`timescale 1ns/1ps
`default_nettype none

module distrib_config (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    cfg_valid,
  output logic                         cfg_ready,
  input  wire distrib_pkg::cfg_write_t cfg_req,
  input  wire logic                    beat_taken,
  input  wire logic                    beat_last,
  output distrib_pkg::chan_mask_t      enable_mask
);

  import distrib_pkg::*;

  localparam chan_mask_t mask_all = '1;

  // high between the first and the last beat of a packet
  logic packet_open;
  logic cfg_xfer;

  //////////////////////////////
  // packet tracking

  always_ff @(posedge clk) begin
    if (rst) begin
      packet_open <= 1'b0;
    end else if (beat_taken) begin
      packet_open <= ~beat_last;
    end
  end

  //////////////////////////////
  // mask register

  // also blocked while a beat is taken, which may open a packet
  assign cfg_ready = ~packet_open & ~beat_taken;
  assign cfg_xfer  = cfg_valid & cfg_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      enable_mask <= mask_all;
    end else if (cfg_xfer) begin
      enable_mask <= cfg_req.mask;
    end
  end

  //////////////////////////////
  // checks

  // no channel sees a partial packet
  a_mask_frozen : assert property (
    @(posedge clk) disable iff (rst)
    packet_open |=> $stable(enable_mask)
  );

endmodule

`default_nettype wire

//--- verilog/distrib_top.sv
/*
  Stream distributor with one FIFO per output channel.
  Input to output latency is two cycles when the FIFOs are empty.
*/
`timescale 1ns/1ps
`default_nettype none
`include "distrib_macros.svh"

module distrib_top (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    in_valid,
  output logic                         in_ready,
  input  wire distrib_pkg::beat_t      in_beat,
  input  wire logic                    cfg_valid,
  output logic                         cfg_ready,
  input  wire distrib_pkg::cfg_write_t cfg_req,
  output distrib_pkg::chan_mask_t      out_valid,
  input  wire distrib_pkg::chan_mask_t out_ready,
  output distrib_pkg::beat_vec_t       out_beat
);

  import distrib_pkg::*;

  chan_mask_t enable_mask;
  chan_mask_t dist_valid;
  chan_mask_t dist_ready;
  beat_vec_t  dist_beat;
  logic       beat_taken;
  logic       beat_last;

  distrib_config u_config (
    .clk         (clk),
    .rst         (rst),
    .cfg_valid   (cfg_valid),
    .cfg_ready   (cfg_ready),
    .cfg_req     (cfg_req),
    .beat_taken  (beat_taken),
    .beat_last   (beat_last),
    .enable_mask (enable_mask)
  );

  stream_distrib u_distrib (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_beat     (in_beat),
    .enable_mask (enable_mask),
    .dist_valid  (dist_valid),
    .dist_ready  (dist_ready),
    .dist_beat   (dist_beat),
    .beat_taken  (beat_taken),
    .beat_last   (beat_last)
  );

  // one buffer per consumer
  for (genvar n = 0; n < `DISTRIB_CHANNELS; n++) begin : g_fifo
    stream_fifo u_fifo (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (dist_valid[n]),
      .in_ready  (dist_ready[n]),
      .in_beat   (dist_beat[n]),
      .out_valid (out_valid[n]),
      .out_ready (out_ready[n]),
      .out_beat  (out_beat[n])
    );
  end

endmodule

`default_nettype wire

//--- test/tb_distrib.sv
/*
  Self-checking testbench for the stream distributor.
  Expected beats are queued per channel at each input transfer and
  popped at each output transfer. Assumes 32-bit data and 4 channels.
*/
`timescale 1ns/1ps
`default_nettype none
`include "distrib_macros.svh"

module tb_distrib;

  import distrib_pkg::*;

  logic       clk;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  beat_t      in_beat;
  logic       cfg_valid;
  logic       cfg_ready;
  cfg_write_t cfg_req;
  chan_mask_t out_valid;
  chan_mask_t out_ready;
  beat_vec_t  out_beat;

  // model state
  beat_t      exp_q [`DISTRIB_CHANNELS][$];
  chan_mask_t model_mask;
  chan_mask_t pkt_mask;
  logic       model_open;
  logic [15:0] lfsr;
  int         ready_mode;
  int         mismatch_errors;
  int         other_errors;

  distrib_top DUT (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_beat   (in_beat),
    .cfg_valid (cfg_valid),
    .cfg_ready (cfg_ready),
    .cfg_req   (cfg_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_beat  (out_beat)
  );

  always #20 clk = ~clk;

  //////////////////////////////
  // random source and reference

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // a packet goes to the channels enabled at its first beat
  function automatic chan_mask_t packet_targets(chan_mask_t mask_now, logic in_packet,
                                                chan_mask_t held);
    if (in_packet) begin
      return held;
    end
    return mask_now;
  endfunction

  task automatic check_beat(int ch, string name, beat_t got, beat_t exp);
    if (got !== exp) begin
      $display("Mismatch ch%0d %s got %h expected %h", ch, name, got, exp);
      mismatch_errors++;
    end
  endtask

  task automatic check_mask(string name, chan_mask_t got, chan_mask_t exp);
    if (got !== exp) begin
      $display("Mismatch %s got %h expected %h", name, got, exp);
      mismatch_errors++;
    end
  endtask

  //////////////////////////////
  // drivers

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // per-channel consumer pattern, offset from the input driver
  always @(posedge clk) begin
    #1;
    case (ready_mode)
      1:       out_ready = chan_mask_t'(rand_bits(`DISTRIB_CHANNELS));
      2:       out_ready = ~chan_mask_t'(1);
      default: out_ready = '1;
    endcase
  end

  task automatic send_beat(beat_t b);
    int waited;
    in_valid = 1'b1;
    in_beat  = b;
    waited   = 0;
    @(negedge clk);
    while (!in_ready && waited < 300) begin
      @(negedge clk);
      waited++;
    end
    if (!in_ready) begin
      $display("timeout: input beat %h never accepted", b);
      other_errors++;
    end
    tick();
    in_valid = 1'b0;
  endtask

  task automatic send_packet(int len);
    beat_t b;
    int    gap;
    for (int i = 0; i < len; i++) begin
      gap = rand_bits(1) ? 0 : int'(rand_bits(2));
      repeat (gap) tick();
      b.data = rand_bits(32);
      b.last = (i == len - 1);
      send_beat(b);
    end
  endtask

  task automatic send_random_packet();
    send_packet(int'(rand_bits(3)) % 6 + 1);
  endtask

  task automatic write_cfg(chan_mask_t mask);
    int waited;
    cfg_valid    = 1'b1;
    cfg_req.mask = mask;
    waited       = 0;
    @(negedge clk);
    while (!cfg_ready && waited < 300) begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_ready) begin
      $display("timeout: configuration write %h never accepted", mask);
      other_errors++;
    end
    tick();
    cfg_valid = 1'b0;
  endtask

  // returns once the first beat of a packet has been taken
  task automatic wait_packet_open();
    int waited;
    waited = 0;
    while (!model_open && waited < 300) begin
      tick();
      waited++;
    end
    if (!model_open) begin
      $display("timeout: no packet started before the configuration write");
      other_errors++;
    end
  endtask

  // channel 0 is stalled; wait for the input to block, then release it
  task automatic stall_check();
    int low_run;
    int waited;
    low_run = 0;
    waited  = 0;
    while (low_run < 6 && waited < 300) begin
      @(negedge clk);
      waited++;
      low_run = in_ready ? 0 : low_run + 1;
    end
    if (low_run < 6) begin
      $display("timeout: input never blocked behind the stalled channel");
      other_errors++;
    end else begin
      repeat (10) begin
        @(negedge clk);
        if (in_ready) begin
          $display("in_ready went high while channel 0 was still full");
          other_errors++;
        end
      end
    end
    ready_mode = 0;
  endtask

  //////////////////////////////
  // monitor and scoreboard

  // sampled mid-cycle, so values equal those at the next rising edge
  always @(negedge clk) begin : monitor
    chan_mask_t pending;
    chan_mask_t targets;
    beat_t      exp_b;
    logic       exp_cfg_ready;
    if (!rst) begin
      exp_cfg_ready = !model_open && !(in_valid && in_ready);
      check_mask("cfg_ready", chan_mask_t'(cfg_ready), chan_mask_t'(exp_cfg_ready));
      check_mask("enable_mask", DUT.u_config.enable_mask, model_mask);
      for (int n = 0; n < `DISTRIB_CHANNELS; n++) begin
        pending[n] = (exp_q[n].size() > 0);
      end
      check_mask("out_valid", out_valid & ~pending, '0);
      for (int n = 0; n < `DISTRIB_CHANNELS; n++) begin
        if (out_valid[n] && out_ready[n] && pending[n]) begin
          exp_b = exp_q[n].pop_front();
          check_beat(n, "out_beat", out_beat[n], exp_b);
        end
      end
      if (in_valid && in_ready) begin
        targets = packet_targets(model_mask, model_open, pkt_mask);
        pkt_mask = targets;
        model_open = !in_beat.last;
        for (int n = 0; n < `DISTRIB_CHANNELS; n++) begin
          if (targets[n]) begin
            exp_q[n].push_back(in_beat);
          end
        end
      end
      if (cfg_valid && cfg_ready) begin
        model_mask = cfg_req.mask;
      end
    end
  end

  //////////////////////////////
  // test sequence

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_beat = '0;
    cfg_valid = 1'b0;
    cfg_req = '0;
    out_ready = '1;
    ready_mode = 0;
    lfsr = 16'd8580;
    model_mask = '1;
    pkt_mask = '1;
    model_open = 1'b0;
    mismatch_errors = 0;
    other_errors = 0;

    repeat (8) @(posedge clk);
    #2;
    check_mask("out_valid", out_valid, '0);
    check_mask("in_ready", chan_mask_t'(in_ready), '0);
    check_mask("cfg_ready", chan_mask_t'(cfg_ready), chan_mask_t'(1));
    rst = 1'b0;

    // all enabled, all consumers ready
    repeat (4) send_random_packet();
    // random consumers
    ready_mode = 1;
    repeat (6) send_random_packet();
    // channels 1 and 3 off
    write_cfg(chan_mask_t'(4'h5));
    repeat (4) send_random_packet();
    // write lands only after the packet ends
    fork
      send_packet(6);
      begin
        wait_packet_open();
        write_cfg(chan_mask_t'(4'ha));
      end
    join
    repeat (3) send_random_packet();
    write_cfg('1);
    // fill channel 0
    ready_mode = 2;
    fork
      begin
        send_packet(6);
        send_packet(6);
      end
      stall_check();
    join
    repeat (3) send_random_packet();

    begin : drain
      int waited;
      int left;
      ready_mode = 0;
      waited = 0;
      left = 1;
      while (left != 0 && waited < 500) begin
        tick();
        waited++;
        left = 0;
        for (int n = 0; n < `DISTRIB_CHANNELS; n++) begin
          left += exp_q[n].size();
        end
      end
      for (int n = 0; n < `DISTRIB_CHANNELS; n++) begin
        if (exp_q[n].size() != 0) begin
          $display("channel %0d never delivered %0d expected beats", n, exp_q[n].size());
          other_errors++;
        end
      end
    end

    $display("mismatches: %0d, other errors: %0d", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+verilog
verilog/distrib_pkg.sv
verilog/stream_fifo.sv
verilog/stream_distrib.sv
verilog/distrib_config.sv
verilog/distrib_top.sv
test/tb_distrib.sv

//--- Bender.yml
package:
  name: stream_distrib

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/distrib_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/stream_distrib.sv
      - verilog/distrib_config.sv
      - verilog/distrib_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_distrib.sv
